// ==== mrnw_cfg.svh ====
`ifndef MRNW_CFG_SVH
`define MRNW_CFG_SVH

// port counts.
`define MRNW_NUMRDPT 2
`define MRNW_NUMWRPT 2

// banks. one spare per port on top of the virtual banks.
`define MRNW_NUMVBNK 4
`define MRNW_BITVBNK 2
`define MRNW_NUMPBNK 8
`define MRNW_BITPBNK 3

// rows and words.
`define MRNW_NUMVROW 16
`define MRNW_BITVROW 4
`define MRNW_BITADDR 6
`define MRNW_WIDTH   16

`endif

// ==== mrnw_pkg.sv ====
`default_nettype none

`include "mrnw_cfg.svh"

package mrnw_pkg;

  typedef logic [`MRNW_BITADDR-1:0] addr_t;
  typedef logic [`MRNW_WIDTH-1:0]   data_t;
  typedef logic [`MRNW_BITVROW-1:0] vrow_t;
  typedef logic [`MRNW_BITVBNK-1:0] vbnk_t;
  typedef logic [`MRNW_BITPBNK-1:0] pbnk_t;

  // entry v holds the physical bank of virtual bank v.
  typedef logic [`MRNW_NUMVBNK*`MRNW_BITPBNK-1:0] map_row_t;

  typedef enum logic [1:0] {
    INIT_IDLE,
    INIT_WALK,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

// ==== bank_1rw.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mrnw_cfg.svh"

module bank_1rw (
  input  wire logic            clk,
  input  wire logic            read,
  input  wire logic            write,
  input  wire mrnw_pkg::vrow_t addr,
  input  wire mrnw_pkg::data_t din,
  output mrnw_pkg::data_t      dout
);
  import mrnw_pkg::*;

  data_t mem [`MRNW_NUMVROW];

  // single port. a write wins and dout holds.
  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= din;
    end else if (read) begin
      dout <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== bank_map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mrnw_cfg.svh"

module bank_map_table (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  output logic                          ready,
  input  wire mrnw_pkg::vrow_t          rd_row0,
  input  wire mrnw_pkg::vrow_t          rd_row1,
  input  wire mrnw_pkg::vrow_t          wr_row0,
  input  wire mrnw_pkg::vrow_t          wr_row1,
  output mrnw_pkg::map_row_t            rd_map0,
  output mrnw_pkg::map_row_t            rd_map1,
  output mrnw_pkg::map_row_t            wr_map0,
  output mrnw_pkg::map_row_t            wr_map1,
  input  wire logic [`MRNW_NUMWRPT-1:0] upd_en,
  input  wire mrnw_pkg::vrow_t          upd_row0,
  input  wire mrnw_pkg::vrow_t          upd_row1,
  input  wire mrnw_pkg::vbnk_t          upd_vbnk0,
  input  wire mrnw_pkg::vbnk_t          upd_vbnk1,
  input  wire mrnw_pkg::pbnk_t          upd_pbnk0,
  input  wire mrnw_pkg::pbnk_t          upd_pbnk1
);
  import mrnw_pkg::*;

  map_row_t    map_q [`MRNW_NUMVROW];
  map_row_t    ident_row;
  init_state_t state;
  vrow_t       init_row;

  // virtual bank v sits in physical bank v.
  always_comb begin
    for (int v = 0; v < `MRNW_NUMVBNK; v++) begin
      ident_row[v*`MRNW_BITPBNK +: `MRNW_BITPBNK] = pbnk_t'(v);
    end
  end

  // init walk, one row per cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= INIT_IDLE;
      init_row <= '0;
    end else begin
      case (state)
        INIT_IDLE: state <= INIT_WALK;
        INIT_WALK: begin
          init_row <= init_row + 1'b1;
          if (init_row == vrow_t'(`MRNW_NUMVROW - 1)) begin
            state <= INIT_DONE;
          end
        end
        default: state <= INIT_DONE;
      endcase
    end
  end

  assign ready = (state == INIT_DONE);

  always_ff @(posedge clk) begin
    if (state == INIT_WALK) begin
      map_q[init_row] <= ident_row;
    end else if (ready) begin
      if (upd_en[0]) begin
        map_q[upd_row0][upd_vbnk0*`MRNW_BITPBNK +: `MRNW_BITPBNK] <= upd_pbnk0;
      end
      if (upd_en[1]) begin  // later update, so port 1 wins.
        map_q[upd_row1][upd_vbnk1*`MRNW_BITPBNK +: `MRNW_BITPBNK] <= upd_pbnk1;
      end
    end
  end

  assign rd_map0 = map_q[rd_row0];
  assign rd_map1 = map_q[rd_row1];
  assign wr_map0 = map_q[wr_row0];
  assign wr_map1 = map_q[wr_row1];

endmodule

`default_nettype wire

// ==== mrnw_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mrnw_cfg.svh"

module mrnw_core (
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic                                         ready,
  input  wire logic [`MRNW_NUMWRPT-1:0]                     write,
  input  wire mrnw_pkg::addr_t                              wr_adr0,
  input  wire mrnw_pkg::addr_t                              wr_adr1,
  input  wire mrnw_pkg::data_t                              din0,
  input  wire mrnw_pkg::data_t                              din1,
  input  wire logic [`MRNW_NUMRDPT-1:0]                     read,
  input  wire mrnw_pkg::addr_t                              rd_adr0,
  input  wire mrnw_pkg::addr_t                              rd_adr1,
  output logic [`MRNW_NUMRDPT-1:0]                          rd_vld,
  output mrnw_pkg::data_t                                   rd_dout0,
  output mrnw_pkg::data_t                                   rd_dout1,
  output mrnw_pkg::vrow_t                                   rd_row0,
  output mrnw_pkg::vrow_t                                   rd_row1,
  output mrnw_pkg::vrow_t                                   wr_row0,
  output mrnw_pkg::vrow_t                                   wr_row1,
  input  wire mrnw_pkg::map_row_t                           rd_map0,
  input  wire mrnw_pkg::map_row_t                           rd_map1,
  input  wire mrnw_pkg::map_row_t                           wr_map0,
  input  wire mrnw_pkg::map_row_t                           wr_map1,
  output logic [`MRNW_NUMWRPT-1:0]                          upd_en,
  output mrnw_pkg::vrow_t                                   upd_row0,
  output mrnw_pkg::vrow_t                                   upd_row1,
  output mrnw_pkg::vbnk_t                                   upd_vbnk0,
  output mrnw_pkg::vbnk_t                                   upd_vbnk1,
  output mrnw_pkg::pbnk_t                                   upd_pbnk0,
  output mrnw_pkg::pbnk_t                                   upd_pbnk1,
  output logic [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0]            bnk_read,
  output logic [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0]            bnk_write,
  output mrnw_pkg::vrow_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_addr,
  output mrnw_pkg::data_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_din,
  input  wire mrnw_pkg::data_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_dout
);
  import mrnw_pkg::*;

  logic [`MRNW_NUMRDPT-1:0] rd_en;
  logic [`MRNW_NUMWRPT-1:0] wr_en;
  vbnk_t                    rd_vbnk0, rd_vbnk1;
  vbnk_t                    wr_vbnk0, wr_vbnk1;
  pbnk_t                    rd_pb0, rd_pb1;
  pbnk_t                    wr_pb0, wr_pb1;
  pbnk_t                    rd_pb0_q, rd_pb1_q;
  logic [`MRNW_NUMPBNK-1:0] rd_busy;
  logic [`MRNW_NUMPBNK-1:0] wr_busy0, wr_busy1;

  // banks named by one row of the map.
  function automatic logic [`MRNW_NUMPBNK-1:0] map_mask(input map_row_t row);
    logic [`MRNW_NUMPBNK-1:0] m;
    m = '0;
    for (int v = 0; v < `MRNW_NUMVBNK; v++) begin
      m[row[v*`MRNW_BITPBNK +: `MRNW_BITPBNK]] = 1'b1;
    end
    return m;
  endfunction

  // lowest clear bit.
  function automatic pbnk_t first_free(input logic [`MRNW_NUMPBNK-1:0] busy);
    pbnk_t sel;
    sel = '0;
    for (int b = `MRNW_NUMPBNK - 1; b >= 0; b--) begin
      if (!busy[b]) begin
        sel = pbnk_t'(b);
      end
    end
    return sel;
  endfunction

  assign rd_en = read & {`MRNW_NUMRDPT{ready}};   // dropped until init is done.
  assign wr_en = write & {`MRNW_NUMWRPT{ready}};

  // low bits pick the virtual bank.
  assign rd_vbnk0 = rd_adr0[`MRNW_BITVBNK-1:0];
  assign rd_vbnk1 = rd_adr1[`MRNW_BITVBNK-1:0];
  assign wr_vbnk0 = wr_adr0[`MRNW_BITVBNK-1:0];
  assign wr_vbnk1 = wr_adr1[`MRNW_BITVBNK-1:0];
  assign rd_row0  = rd_adr0[`MRNW_BITADDR-1:`MRNW_BITVBNK];
  assign rd_row1  = rd_adr1[`MRNW_BITADDR-1:`MRNW_BITVBNK];
  assign wr_row0  = wr_adr0[`MRNW_BITADDR-1:`MRNW_BITVBNK];
  assign wr_row1  = wr_adr1[`MRNW_BITADDR-1:`MRNW_BITVBNK];

  assign rd_pb0 = rd_map0[rd_vbnk0*`MRNW_BITPBNK +: `MRNW_BITPBNK];
  assign rd_pb1 = rd_map1[rd_vbnk1*`MRNW_BITPBNK +: `MRNW_BITPBNK];

  always_comb begin
    rd_busy = '0;
    if (rd_en[0]) begin
      rd_busy[rd_pb0] = 1'b1;
    end
    if (rd_en[1]) begin
      rd_busy[rd_pb1] = 1'b1;
    end
  end

  // writer 0 first, then writer 1 around it.
  assign wr_busy0 = map_mask(wr_map0) | rd_busy;
  assign wr_pb0   = first_free(wr_busy0);

  always_comb begin
    wr_busy1 = map_mask(wr_map1) | rd_busy;
    if (wr_en[0]) begin
      wr_busy1[wr_pb0] = 1'b1;
    end
  end

  assign wr_pb1 = first_free(wr_busy1);

  // remap to the new bank, the old one goes free.
  assign upd_en    = wr_en;
  assign upd_row0  = wr_row0;
  assign upd_row1  = wr_row1;
  assign upd_vbnk0 = wr_vbnk0;
  assign upd_vbnk1 = wr_vbnk1;
  assign upd_pbnk0 = wr_pb0;
  assign upd_pbnk1 = wr_pb1;

  always_comb begin
    bnk_read  = '0;
    bnk_write = '0;
    bnk_addr  = '0;
    bnk_din   = '0;
    for (int b = 0; b < `MRNW_NUMPBNK; b++) begin
      bnk_read[b]                 = rd_en[0] && (rd_pb0 == pbnk_t'(b));
      bnk_read[`MRNW_NUMPBNK + b] = rd_en[1] && (rd_pb1 == pbnk_t'(b));
      bnk_addr[b]                 = rd_row0;
      bnk_addr[`MRNW_NUMPBNK + b] = rd_row1;
      for (int r = 0; r < `MRNW_NUMRDPT; r++) begin
        if (wr_en[0] && (wr_pb0 == pbnk_t'(b))) begin   // same bank in each replica.
          bnk_write[r*`MRNW_NUMPBNK + b] = 1'b1;
          bnk_addr[r*`MRNW_NUMPBNK + b]  = wr_row0;
          bnk_din[r*`MRNW_NUMPBNK + b]   = din0;
        end
        if (wr_en[1] && (wr_pb1 == pbnk_t'(b))) begin
          bnk_write[r*`MRNW_NUMPBNK + b] = 1'b1;
          bnk_addr[r*`MRNW_NUMPBNK + b]  = wr_row1;
          bnk_din[r*`MRNW_NUMPBNK + b]   = din1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= rd_en;
    end
    rd_pb0_q <= rd_pb0;
    rd_pb1_q <= rd_pb1;
  end

  // port r reads from replica r.
  assign rd_dout0 = bnk_dout[rd_pb0_q];
  assign rd_dout1 = bnk_dout[`MRNW_NUMPBNK + rd_pb1_q];

endmodule

`default_nettype wire

// ==== mrnw_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mrnw_cfg.svh"

module mrnw_top (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  output logic                          ready,
  input  wire logic [`MRNW_NUMWRPT-1:0] write,
  input  wire mrnw_pkg::addr_t          wr_adr0,
  input  wire mrnw_pkg::addr_t          wr_adr1,
  input  wire mrnw_pkg::data_t          din0,
  input  wire mrnw_pkg::data_t          din1,
  input  wire logic [`MRNW_NUMRDPT-1:0] read,
  input  wire mrnw_pkg::addr_t          rd_adr0,
  input  wire mrnw_pkg::addr_t          rd_adr1,
  output logic [`MRNW_NUMRDPT-1:0]      rd_vld,
  output mrnw_pkg::data_t               rd_dout0,
  output mrnw_pkg::data_t               rd_dout1
);
  import mrnw_pkg::*;

  vrow_t                    rd_row0, rd_row1;
  vrow_t                    wr_row0, wr_row1;
  map_row_t                 rd_map0, rd_map1;
  map_row_t                 wr_map0, wr_map1;
  logic [`MRNW_NUMWRPT-1:0] upd_en;
  vrow_t                    upd_row0, upd_row1;
  vbnk_t                    upd_vbnk0, upd_vbnk1;
  pbnk_t                    upd_pbnk0, upd_pbnk1;

  logic [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0]  bnk_read;
  logic [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0]  bnk_write;
  vrow_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_addr;
  data_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_din;
  data_t [`MRNW_NUMRDPT*`MRNW_NUMPBNK-1:0] bnk_dout;

  mrnw_core core_i (
    .clk       (clk),       .rst_n     (rst_n),     .ready     (ready),
    .write     (write),     .wr_adr0   (wr_adr0),   .wr_adr1   (wr_adr1),
    .din0      (din0),      .din1      (din1),
    .read      (read),      .rd_adr0   (rd_adr0),   .rd_adr1   (rd_adr1),
    .rd_vld    (rd_vld),    .rd_dout0  (rd_dout0),  .rd_dout1  (rd_dout1),
    .rd_row0   (rd_row0),   .rd_row1   (rd_row1),
    .wr_row0   (wr_row0),   .wr_row1   (wr_row1),
    .rd_map0   (rd_map0),   .rd_map1   (rd_map1),
    .wr_map0   (wr_map0),   .wr_map1   (wr_map1),
    .upd_en    (upd_en),    .upd_row0  (upd_row0),  .upd_row1  (upd_row1),
    .upd_vbnk0 (upd_vbnk0), .upd_vbnk1 (upd_vbnk1),
    .upd_pbnk0 (upd_pbnk0), .upd_pbnk1 (upd_pbnk1),
    .bnk_read  (bnk_read),  .bnk_write (bnk_write), .bnk_addr  (bnk_addr),
    .bnk_din   (bnk_din),   .bnk_dout  (bnk_dout)
  );

  bank_map_table map_i (
    .clk       (clk),       .rst_n     (rst_n),     .ready     (ready),
    .rd_row0   (rd_row0),   .rd_row1   (rd_row1),
    .wr_row0   (wr_row0),   .wr_row1   (wr_row1),
    .rd_map0   (rd_map0),   .rd_map1   (rd_map1),
    .wr_map0   (wr_map0),   .wr_map1   (wr_map1),
    .upd_en    (upd_en),    .upd_row0  (upd_row0),  .upd_row1  (upd_row1),
    .upd_vbnk0 (upd_vbnk0), .upd_vbnk1 (upd_vbnk1),
    .upd_pbnk0 (upd_pbnk0), .upd_pbnk1 (upd_pbnk1)
  );

  // one replica of the physical banks per read port.
  for (genvar r = 0; r < `MRNW_NUMRDPT; r++) begin : g_rep
    for (genvar b = 0; b < `MRNW_NUMPBNK; b++) begin : g_bank
      bank_1rw bank_i (
        .clk   (clk),
        .read  (bnk_read[r*`MRNW_NUMPBNK + b]),
        .write (bnk_write[r*`MRNW_NUMPBNK + b]),
        .addr  (bnk_addr[r*`MRNW_NUMPBNK + b]),
        .din   (bnk_din[r*`MRNW_NUMPBNK + b]),
        .dout  (bnk_dout[r*`MRNW_NUMPBNK + b])
      );
    end
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== mrnw_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mrnw_cfg.svh"

module mrnw_tb;
  import mrnw_pkg::*;

  localparam int num_addr = 1 << `MRNW_BITADDR;
  // reset, init, ignored reads, fill, readback, dual, readback, random, collisions, tail.
  localparam int total_cycles = 5 + 40 + 40 + 64 + 64 + 48 + 64 + 2000 + 32 + 4;

  logic                     clk;
  logic                     rst_n;
  logic                     ready;
  logic [`MRNW_NUMWRPT-1:0] write;
  addr_t                    wr_adr0, wr_adr1;
  data_t                    din0, din1;
  logic [`MRNW_NUMRDPT-1:0] read;
  addr_t                    rd_adr0, rd_adr1;
  logic [`MRNW_NUMRDPT-1:0] rd_vld;
  data_t                    rd_dout0, rd_dout1;

  data_t       model [num_addr];
  logic        written [num_addr];
  logic [31:0] lfsr = 32'h5278_9721;
  logic [1:0]  exp_vld, exp_chk, exp_bad;
  data_t       exp_dat0, exp_dat1, bad0, bad1;
  logic        ign_chk;
  logic        ready_seen;
  int          n_ign;

  tb_clock_gen #(.period_ns(40)) clk_gen_i (.clk(clk));

  mrnw_top mrnw_top_i (
    .clk     (clk),     .rst_n   (rst_n),   .ready   (ready),
    .write   (write),   .wr_adr0 (wr_adr0), .wr_adr1 (wr_adr1),
    .din0    (din0),    .din1    (din1),
    .read    (read),    .rd_adr0 (rd_adr0), .rd_adr1 (rd_adr1),
    .rd_vld  (rd_vld),  .rd_dout0(rd_dout0), .rd_dout1(rd_dout1)
  );

  // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1. one step per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      val  = {val[30:0], lfsr[31]};
      lfsr = {lfsr[30:0], fb};
    end
    return val;
  endfunction

  function automatic data_t ref_read(input addr_t a);
    return model[a];  // last write from an earlier cycle.
  endfunction

  function automatic data_t ign_word(input addr_t a);
    return 16'h5a00 | 16'(a);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one cycle of commands. expected reads use the model before this cycle's writes.
  task automatic drive(input logic [1:0] w, input addr_t wa0, input addr_t wa1,
                       input data_t d0, input data_t d1,
                       input logic [1:0] r, input addr_t ra0, input addr_t ra1);
    logic acc;
    @(posedge clk);
    #2;
    acc     = ready;
    write   = w;
    wr_adr0 = wa0;
    wr_adr1 = wa1;
    din0    = d0;
    din1    = d1;
    read    = r;
    rd_adr0 = ra0;
    rd_adr1 = ra1;
    exp_vld    = r & {2{acc}};
    exp_chk[0] = acc & r[0] & written[ra0];
    exp_chk[1] = acc & r[1] & written[ra1];
    exp_dat0   = ref_read(ra0);
    exp_dat1   = ref_read(ra1);
    exp_bad[0] = ign_chk & acc & r[0] & ~written[ra0];
    exp_bad[1] = ign_chk & acc & r[1] & ~written[ra1];
    bad0       = ign_word(ra0);
    bad1       = ign_word(ra1);
    if (acc && w[0]) begin
      model[wa0]   = d0;
      written[wa0] = 1'b1;
    end
    if (acc && w[1]) begin  // port 1 last, so it wins.
      model[wa1]   = d1;
      written[wa1] = 1'b1;
    end
  endtask

  task automatic read_all();
    for (int a = 0; a < num_addr; a++) begin
      drive(2'b00, '0, '0, '0, '0, 2'b11, addr_t'(a), addr_t'(num_addr - 1 - a));
    end
  endtask

  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      check_value("ready", 32'(ready), 32'd0);
    end
    if (ready_seen) begin
      check_value("ready", 32'(ready), 32'd1);
    end
    check_value("rd_vld", 32'(rd_vld), 32'(exp_vld));
    if (exp_chk[0]) check_value("rd_dout0", 32'(rd_dout0), 32'(exp_dat0));
    if (exp_chk[1]) check_value("rd_dout1", 32'(rd_dout1), 32'(exp_dat1));
    if (exp_bad[0]) check_value("rd_dout0 is ignored data", 32'(rd_dout0 === bad0), 32'd0);
    if (exp_bad[1]) check_value("rd_dout1 is ignored data", 32'(rd_dout1 === bad1), 32'd0);
  end

  initial begin
    #(total_cycles * 2 * 40);
    $display("ERROR: simulation timed out after %0d cycles", total_cycles * 2);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [1:0] w, r;
    addr_t      a0, a1, a2, a3;
    data_t      d, e;
    int         row0, row1, vb;
    rst_n   = 1'b0;
    write   = '0;
    wr_adr0 = '0;
    wr_adr1 = '0;
    din0    = '0;
    din1    = '0;
    read    = '0;
    rd_adr0 = '0;
    rd_adr1 = '0;
    exp_vld = '0;
    exp_chk = '0;
    exp_bad = '0;
    ign_chk = 1'b0;
    ready_seen = 1'b0;
    for (int i = 0; i < num_addr; i++) begin
      written[i] = 1'b0;
    end
    repeat (5) drive(2'b00, '0, '0, '0, '0, 2'b00, '0, '0);
    rst_n = 1'b1;

    // commands during init must vanish.
    n_ign = 0;
    while (ready !== 1'b1) begin
      if (n_ign == 40) begin
        $display("ERROR: ready still low 40 cycles after reset release");
        $display("Test failed");
        $fatal(1, "init did not finish");
      end else begin
        drive(2'b11, addr_t'(n_ign), addr_t'(n_ign + 32), ign_word(addr_t'(n_ign)),
              ign_word(addr_t'(n_ign + 32)), 2'b11, addr_t'(n_ign), addr_t'(n_ign + 32));
        n_ign++;
      end
    end
    ready_seen = 1'b1;
    ign_chk = 1'b1;
    for (int i = 0; i < n_ign; i++) begin
      drive(2'b00, '0, '0, '0, '0, 2'b11, addr_t'(i), addr_t'(i + 32));
    end
    ign_chk = 1'b0;

    for (int a = 0; a < num_addr; a++) begin
      d = data_t'(take_bits(16));
      if (a % 2 == 0) drive(2'b01, addr_t'(a), '0, d, '0, 2'b00, '0, '0);
      else drive(2'b10, '0, addr_t'(a), '0, d, 2'b00, '0, '0);
    end
    read_all();

    // same virtual bank on both writers and reads in the same rows.
    for (int k = 0; k < 48; k++) begin
      row0 = k % `MRNW_NUMVROW;
      row1 = (5 * k + 3) % `MRNW_NUMVROW;
      vb   = k / `MRNW_NUMVROW;
      d    = data_t'(take_bits(16));
      e    = data_t'(take_bits(16));
      drive(2'b11, addr_t'(row0 * `MRNW_NUMVBNK + vb), addr_t'(row1 * `MRNW_NUMVBNK + vb),
            d, e, 2'b11, addr_t'(row0 * `MRNW_NUMVBNK + (vb ^ 1)),
            addr_t'(row1 * `MRNW_NUMVBNK + (vb ^ 3)));
    end
    read_all();

    for (int c = 0; c < 2000; c++) begin
      w  = 2'(take_bits(2));
      r  = 2'(take_bits(2));
      a0 = addr_t'(take_bits(6));
      a1 = addr_t'(take_bits(6));
      a2 = addr_t'(take_bits(6));
      a3 = addr_t'(take_bits(6));
      d  = data_t'(take_bits(16));
      e  = data_t'(take_bits(16));
      drive(w, a0, a1, d, e, r, a2, a3);
    end

    for (int c = 0; c < 8; c++) begin
      a0 = addr_t'(take_bits(6));
      a1 = addr_t'(take_bits(6));
      drive(2'b11, a0, a0, data_t'(take_bits(16)), data_t'(take_bits(16)), 2'b00, '0, '0);
      drive(2'b01, a1, '0, data_t'(take_bits(16)), '0, 2'b11, a0, a1);
      drive(2'b10, '0, a0, '0, data_t'(take_bits(16)), 2'b11, a1, a0);
      drive(2'b00, '0, '0, '0, '0, 2'b11, a0, a0);
    end
    repeat (2) drive(2'b00, '0, '0, '0, '0, 2'b00, '0, '0);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
mrnw_pkg.sv
bank_1rw.sv
bank_map_table.sv
mrnw_core.sv
mrnw_top.sv
tb_clock_gen.sv
mrnw_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module mrnw_tb -f filelist.f -o mrnw_sim &&
./obj_dir/mrnw_sim | tee /dev/stderr | grep -qx "Test completed successfully" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
